//--- testbench/l1d_testdata.hex
// id op size address wdata exp_rdata exp_refill
// op 0 read, 1 write; size 0 byte, 1 half, 2 word; exp_rdata unused for writes
01 0 2 00001238 00000000 5a5a1238 1
02 0 2 0000123c 00000000 5a5a123c 0
03 0 2 00001230 00000000 5a5a1230 0
04 1 0 00001231 000000ab 00000000 0
05 0 2 00001230 00000000 5a5aab30 0
06 1 1 00001236 0000beef 00000000 0
07 0 2 00001234 00000000 beef1234 0
08 1 2 0000123c cafef00d 00000000 0
09 0 2 0000123c 00000000 cafef00d 0
0a 1 0 00001238 00000077 00000000 0
0b 0 2 00001238 00000000 5a5a1277 0
0c 1 2 00002040 12345678 00000000 0
0d 0 2 00002040 00000000 12345678 1
0e 0 2 00002044 00000000 5a5a2044 0
0f 1 0 00002053 000000c3 00000000 0
10 0 2 00002050 00000000 c35a2050 1
11 0 2 00005230 00000000 5a5a5230 1
12 0 2 00001230 00000000 5a5aab30 1
13 0 2 00001234 00000000 beef1234 0
14 0 2 0000123c 00000000 cafef00d 0
15 0 2 00005234 00000000 5a5a5234 1
16 0 2 fffffff0 00000000 a5a5fff0 1
17 1 1 fffffff4 00001111 00000000 0
18 0 2 fffffff4 00000000 a5a51111 0
19 1 0 fffffffe 0000005e 00000000 0
1a 0 2 fffffffc 00000000 a55efffc 0
1b 0 2 000003f8 00000000 5a5a03f8 1
1c 0 2 fffffff4 00000000 a5a51111 1
1d 0 2 00001239 00000000 5a5a1277 1
1e 1 2 00000000 deadbeef 00000000 0
1f 0 2 00000000 00000000 deadbeef 1

//--- sources.f
common/l1d_pkg.sv
cache/refill_beat_counter.sv
cache/line_store.sv
cache/fill_buffer.sv
cache/l1d_ctrl_fsm.sv
cache/l1d_cache.sv
testbench/l1d_checker.sv
testbench/l1d_cache_sva.sv
testbench/tb_l1d_cache.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module tb_l1d_cache -f sources.f \
  -Mdir obj_dir -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Simulation build or run error"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- testbench/tb_l1d_cache.sv
// Testbench top for the L1 data cache
// Clock, reset, memory model with random back-pressure
// Operations and expected results come from the test data file
`timescale 1ns/1ps
`default_nettype none

module tb_l1d_cache;

  localparam int fields     = 7;
  localparam int max_ops    = 64;
  localparam int wait_limit = 200;

  logic                  clk;
  logic                  rst;
  logic                  core_req;
  logic                  core_write;
  l1d_pkg::addr_t        core_addr;
  logic [31:0]           core_wdata;
  l1d_pkg::access_size_e core_size;
  logic [31:0]           core_rdata;
  logic                  core_wait;
  logic [31:0]           mem_rdata;
  logic                  mem_wait;
  logic                  mem_req;
  logic                  mem_write;
  logic [31:0]           mem_addr;
  logic [31:0]           mem_wdata;
  l1d_pkg::access_size_e mem_size;

  // Current operation as seen by the checker
  logic        op_start;
  logic        op_done;
  logic [31:0] test_id;
  logic [31:0] op_code;
  logic [31:0] op_size;
  logic [31:0] op_addr;
  logic [31:0] exp_rdata;
  logic [31:0] exp_refill;
  int          tests_run;
  int          tests_failed;

  logic [31:0] vectors [max_ops*fields];
  logic [31:0] mem_words [logic [31:0]];
  logic [31:0] lfsr = 32'ha06b_c26b;

  l1d_cache l1d_cache_i (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .core_size  (core_size),
    .core_rdata (core_rdata),
    .core_wait  (core_wait),
    .mem_rdata  (mem_rdata),
    .mem_wait   (mem_wait),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_size   (mem_size)
  );

  l1d_checker checker_i (
    .clk          (clk),
    .rst          (rst),
    .op_start     (op_start),
    .op_done      (op_done),
    .test_id      (test_id),
    .op_code      (op_code),
    .op_size      (op_size),
    .op_addr      (op_addr),
    .op_wdata     (core_wdata),
    .exp_rdata    (exp_rdata),
    .exp_refill   (exp_refill),
    .core_rdata   (core_rdata),
    .core_wait    (core_wait),
    .mem_req      (mem_req),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_size     (mem_size),
    .tests_run    (tests_run),
    .tests_failed (tests_failed)
  );

  bind l1d_cache l1d_cache_sva sva_i (
    .clk       (clk),
    .rst       (rst),
    .core_wait (core_wait),
    .mem_req   (mem_req),
    .mem_write (mem_write)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==============================
  // Memory model
  // ==============================
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two LFSR bits give 0 to 3 wait cycles
  task automatic draw_delay(output int n);
    n = 0;
    for (int i = 0; i < 2; i++)
    begin
      lfsr = lfsr_step(lfsr);
      n = (n << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic logic [31:0] read_word(logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:2], 2'b00};
    if (mem_words.exists(a))
      return mem_words[a];
    return a ^ 32'h5a5a_0000;
  endfunction

  // Byte lane, half lane pair or whole word
  task automatic write_word(logic [31:0] addr, logic [1:0] size, logic [31:0] data);
    logic [31:0] a;
    logic [31:0] w;
    logic [3:0]  lanes;
    a = {addr[31:2], 2'b00};
    w = read_word(a);
    case (size)
      2'd0:    lanes = 4'b0001 << addr[1:0];
      2'd1:    lanes = addr[1] ? 4'b1100 : 4'b0011;
      default: lanes = 4'b1111;
    endcase
    for (int b = 0; b < 4; b++)
    begin
      if (lanes[b])
        w[b*8 +: 8] = data[b*8 +: 8];
    end
    mem_words[a] = w;
  endtask

  initial
  begin : memory_model
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [1:0]  size;
    logic        is_write;
    int          delay;
    mem_wait  = 1'b0;
    mem_rdata = '0;
    forever
    begin
      @(negedge clk);
      if (!rst && mem_req)
      begin
        addr     = mem_addr;
        wdata    = mem_wdata;
        size     = mem_size;
        is_write = mem_write;
        draw_delay(delay);
        @(posedge clk);
        #1;
        while (delay > 0)
        begin
          mem_wait = 1'b1;
          @(posedge clk);
          #1;
          delay--;
        end
        mem_wait = 1'b0;
        if (is_write)
          write_word(addr, size, wdata);
        else
          mem_rdata = read_word(addr);
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  task automatic run_operation(int n, output logic timed_out);
    int base;
    int cycles;
    base       = n * fields;
    test_id    = vectors[base];
    op_code    = vectors[base+1];
    op_size    = vectors[base+2];
    op_addr    = vectors[base+3];
    exp_rdata  = vectors[base+5];
    exp_refill = vectors[base+6];
    core_req   = 1'b1;
    core_write = op_code[0];
    core_addr  = op_addr;
    core_wdata = vectors[base+4];
    core_size  = l1d_pkg::access_size_e'(op_size[1:0]);
    op_start   = 1'b1;
    @(posedge clk);
    #1;
    core_req = 1'b0;
    op_start = 1'b0;
    cycles   = 0;
    while (core_wait && cycles < wait_limit)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    timed_out = core_wait;
    if (!timed_out)
    begin
      op_done = 1'b1;
      @(posedge clk);
      #1;
      op_done = 1'b0;
    end
  endtask

  initial
  begin : stimulus
    int   n;
    logic timed_out;
    logic ok;
    rst        = 1'b1;
    core_req   = 1'b0;
    core_write = 1'b0;
    core_addr  = '0;
    core_wdata = '0;
    core_size  = l1d_pkg::size_word;
    op_start   = 1'b0;
    op_done    = 1'b0;
    test_id    = '0;
    op_code    = '0;
    op_size    = '0;
    op_addr    = '0;
    exp_rdata  = '0;
    exp_refill = '0;
    for (int i = 0; i < max_ops*fields; i++)
      vectors[i] = '1;
    $readmemh("testbench/l1d_testdata.hex", vectors);
    repeat (8) @(posedge clk);
    #1;
    rst       = 1'b0;
    timed_out = 1'b0;
    n         = 0;
    while (n < max_ops && vectors[n*fields] != 32'hffff_ffff && !timed_out)
    begin
      run_operation(n, timed_out);
      n++;
    end
    if (timed_out)
      $display("Timeout: core_wait stayed high in test %0d", test_id);
    if (n == 0)
      $display("No operations were loaded from the test data file");
    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    ok = !timed_out && n > 0 && tests_failed == 0 && tests_run == n;
    if (ok)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/l1d_cache_sva.sv
// Protocol assertions for the cache top level
// Memory strobe width, idle after reset, write qualifier
`timescale 1ns/1ps
`default_nettype none

module l1d_cache_sva (
  input wire clk,
  input wire rst,
  input wire core_wait,
  input wire mem_req,
  input wire mem_write
);

  // Request strobe is a single-cycle pulse
  mem_req_pulse: assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
    else $error("mem_req high in two consecutive cycles");

  idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !core_wait)
    else $error("core_wait high right after reset");

  // Write qualifier only alongside the strobe
  write_needs_req: assert property (@(posedge clk) disable iff (rst) mem_write |-> mem_req)
    else $error("mem_write high without mem_req");

endmodule

`default_nettype wire

//--- testbench/l1d_checker.sv
// Result checker for the L1 data cache testbench
// Checks every memory strobe of an operation, the returned read word and hit latency
// Prints one line per finished test
`timescale 1ns/1ps
`default_nettype none

module l1d_checker (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   op_start,
  input  wire                   op_done,
  input  wire   [31:0]          test_id,
  input  wire   [31:0]          op_code,
  input  wire   [31:0]          op_size,
  input  wire   [31:0]          op_addr,
  input  wire   [31:0]          op_wdata,
  input  wire   [31:0]          exp_rdata,
  input  wire   [31:0]          exp_refill,
  input  wire   [31:0]          core_rdata,
  input  wire                   core_wait,
  input  wire                   mem_req,
  input  wire                   mem_write,
  input  wire   [31:0]          mem_addr,
  input  wire   [31:0]          mem_wdata,
  input  l1d_pkg::access_size_e mem_size,
  output int                    tests_run,
  output int                    tests_failed
);

  logic [31:0] cur_id;
  logic [31:0] cur_op;
  logic [31:0] cur_size;
  logic [31:0] cur_addr;
  logic [31:0] cur_wdata;
  logic [31:0] cur_rdata;
  logic [31:0] cur_refill;
  int          pulses;
  int          busy_cycles;
  int          errors;

  initial
  begin
    tests_run    = 0;
    tests_failed = 0;
    pulses       = 0;
    busy_cycles  = 0;
    errors       = 0;
  end

  task automatic check_field(string what, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] test %0d %s expected %h actual %h", cur_id, what, expected, actual);
      errors++;
    end
  endtask

  // Refill beats walk the line and a store goes out as requested
  task automatic check_pulse();
    logic [31:0] exp_addr;
    logic [31:0] exp_size;
    logic [31:0] exp_write;
    logic [31:0] exp_wdata;
    if (cur_op == 32'd0)
    begin
      exp_addr  = {cur_addr[31:4], 2'(pulses), 2'b00};
      exp_size  = 32'd2;
      exp_write = 32'd0;
    end
    else
    begin
      exp_addr  = cur_addr;
      exp_size  = cur_size;
      exp_write = 32'd1;
    end
    check_field("mem_addr", exp_addr, mem_addr);
    check_field("mem_size", exp_size, 32'(mem_size));
    check_field("mem_write", exp_write, 32'(mem_write));
    // Store data copied into every lane
    if (cur_op != 32'd0)
    begin
      case (cur_size)
        32'd0:   exp_wdata = {4{cur_wdata[7:0]}};
        32'd1:   exp_wdata = {2{cur_wdata[15:0]}};
        default: exp_wdata = cur_wdata;
      endcase
      check_field("mem_wdata", exp_wdata, mem_wdata);
    end
    pulses++;
  endtask

  task automatic finish_op();
    int exp_pulses;
    if (cur_op == 32'd0)
    begin
      exp_pulses = (cur_refill != 32'd0) ? 4 : 0;
      check_field("core_rdata", cur_rdata, core_rdata);
      // A hit answers after a single lookup cycle
      if (cur_refill == 32'd0)
        check_field("core_wait cycles", 32'd1, 32'(busy_cycles));
    end
    else
      exp_pulses = 1;
    check_field("mem_req pulses", 32'(exp_pulses), 32'(pulses));
    tests_run++;
    if (errors == 0)
      $display("test %0d ok", cur_id);
    else
    begin
      $display("test %0d failed", cur_id);
      tests_failed++;
    end
  endtask

  // Sampled mid-cycle where all inputs have settled
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (op_start)
      begin
        cur_id      = test_id;
        cur_op      = op_code;
        cur_size    = op_size;
        cur_addr    = op_addr;
        cur_wdata   = op_wdata;
        cur_rdata   = exp_rdata;
        cur_refill  = exp_refill;
        pulses      = 0;
        busy_cycles = 0;
        errors      = 0;
      end
      if (core_wait)
        busy_cycles++;
      if (mem_req)
        check_pulse();
      if (op_done)
        finish_op();
    end
  end

endmodule

`default_nettype wire

//--- cache/l1d_cache.sv
// L1 data cache top level
// Direct mapped, 64 lines of 16 bytes, write-through without allocate
// Connects controller, refill beat counter, line store and fill buffer
`timescale 1ns/1ps
`default_nettype none

module l1d_cache (
  input  wire                                     clk,
  input  wire                                     rst,
  // Core side
  input  wire                                     core_req,
  input  wire                                     core_write,
  input  l1d_pkg::addr_t                          core_addr,
  input  wire         [l1d_pkg::data_w-1:0]       core_wdata,
  input  l1d_pkg::access_size_e                   core_size,
  output logic        [l1d_pkg::data_w-1:0]       core_rdata,
  output logic                                    core_wait,
  // Memory side
  input  wire         [l1d_pkg::data_w-1:0]       mem_rdata,
  input  wire                                     mem_wait,
  output logic                                    mem_req,
  output logic                                    mem_write,
  output logic        [l1d_pkg::addr_w-1:0]       mem_addr,
  output logic        [l1d_pkg::data_w-1:0]       mem_wdata,
  output l1d_pkg::access_size_e                   mem_size
);

  l1d_pkg::addr_t                      req_addr;
  logic [l1d_pkg::data_w-1:0]          req_wdata;
  l1d_pkg::access_size_e               req_size;
  logic [l1d_pkg::index_w-1:0]         lookup_index;
  logic                                beat_clear;
  logic                                beat_step;
  logic                                beat_capture;
  logic                                line_fill;
  logic                                store_hit;
  logic                                hit;
  logic [l1d_pkg::word_sel_w-1:0]      beat;
  logic                                last_beat;
  logic [l1d_pkg::line_w-1:0]          fill_line;
  logic [l1d_pkg::line_w-1:0]          rd_line;

  l1d_ctrl_fsm ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .core_req     (core_req),
    .core_write   (core_write),
    .core_addr    (core_addr),
    .core_wdata   (core_wdata),
    .core_size    (core_size),
    .mem_wait     (mem_wait),
    .hit          (hit),
    .beat         (beat),
    .last_beat    (last_beat),
    .core_wait    (core_wait),
    .mem_req      (mem_req),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_size     (mem_size),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_size     (req_size),
    .lookup_index (lookup_index),
    .beat_clear   (beat_clear),
    .beat_step    (beat_step),
    .beat_capture (beat_capture),
    .line_fill    (line_fill),
    .store_hit    (store_hit)
  );

  refill_beat_counter beat_cnt_i (
    .clk        (clk),
    .rst        (rst),
    .beat_clear (beat_clear),
    .beat_step  (beat_step),
    .beat       (beat),
    .last_beat  (last_beat)
  );

  line_store store_i (
    .clk          (clk),
    .rst          (rst),
    .lookup_index (lookup_index),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_size     (req_size),
    .line_fill    (line_fill),
    .fill_line    (fill_line),
    .store_hit    (store_hit),
    .hit          (hit),
    .rd_line      (rd_line)
  );

  // Read word taken from the line on a lookup hit
  fill_buffer fill_i (
    .clk          (clk),
    .rst          (rst),
    .mem_rdata    (mem_rdata),
    .beat         (beat),
    .beat_capture (beat_capture),
    .req_word     (req_addr.word),
    .rd_line      (rd_line),
    .hit_capture  (beat_clear && hit),
    .fill_line    (fill_line),
    .core_rdata   (core_rdata)
  );

endmodule

`default_nettype wire

//--- cache/l1d_ctrl_fsm.sv
// Cache controller FSM
// Latches the core request, runs lookup, four-beat refill and write-through
// Drives the memory strobes and steers counter, line store and fill buffer
`timescale 1ns/1ps
`default_nettype none

module l1d_ctrl_fsm (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 core_req,
  input  wire                                 core_write,
  input  l1d_pkg::addr_t                      core_addr,
  input  wire   [l1d_pkg::data_w-1:0]         core_wdata,
  input  l1d_pkg::access_size_e               core_size,
  input  wire                                 mem_wait,
  input  wire                                 hit,
  input  wire   [l1d_pkg::word_sel_w-1:0]     beat,
  input  wire                                 last_beat,
  output logic                                core_wait,
  output logic                                mem_req,
  output logic                                mem_write,
  output logic  [l1d_pkg::addr_w-1:0]         mem_addr,
  output logic  [l1d_pkg::data_w-1:0]         mem_wdata,
  output l1d_pkg::access_size_e               mem_size,
  output l1d_pkg::addr_t                      req_addr,
  output logic  [l1d_pkg::data_w-1:0]         req_wdata,
  output l1d_pkg::access_size_e               req_size,
  output logic  [l1d_pkg::index_w-1:0]        lookup_index,
  output logic                                beat_clear,
  output logic                                beat_step,
  output logic                                beat_capture,
  output logic                                line_fill,
  output logic                                store_hit
);

  l1d_pkg::ctrl_state_e state;
  l1d_pkg::ctrl_state_e state_next;
  l1d_pkg::addr_t       fill_addr;
  logic                 accept;

  assign accept = (state == l1d_pkg::st_idle) && core_req;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= l1d_pkg::st_idle;
    else
      state <= state_next;
  end

  // Request latch, loaded at the acceptance edge
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_addr  <= core_addr;
      req_wdata <= core_wdata;
      req_size  <= core_size;
    end
  end

  // Line base plus current beat
  always_comb
  begin
    fill_addr          = req_addr;
    fill_addr.word     = beat;
    fill_addr.byte_sel = '0;
  end

  assign core_wait    = (state != l1d_pkg::st_idle);
  assign lookup_index = (state == l1d_pkg::st_idle) ? core_addr.index : req_addr.index;
  assign mem_wdata    = l1d_pkg::replicate_wdata(req_size, req_wdata);

  // ==============================
  // Next state and strobes
  // ==============================
  always_comb
  begin
    state_next   = state;
    mem_req      = 1'b0;
    mem_write    = 1'b0;
    mem_addr     = req_addr;
    mem_size     = req_size;
    beat_clear   = 1'b0;
    beat_step    = 1'b0;
    beat_capture = 1'b0;
    line_fill    = 1'b0;
    store_hit    = 1'b0;
    case (state)
      l1d_pkg::st_idle:
      begin
        if (core_req)
          state_next = core_write ? l1d_pkg::st_lookup_write : l1d_pkg::st_lookup_read;
      end
      l1d_pkg::st_lookup_read:
      begin
        beat_clear = 1'b1;
        state_next = hit ? l1d_pkg::st_idle : l1d_pkg::st_fill_req;
      end
      l1d_pkg::st_fill_req:
      begin
        mem_req    = 1'b1;
        mem_addr   = fill_addr;
        mem_size   = l1d_pkg::size_word;
        state_next = l1d_pkg::st_fill_wait;
      end
      l1d_pkg::st_fill_wait:
      begin
        mem_addr = fill_addr;
        mem_size = l1d_pkg::size_word;
        if (!mem_wait)
        begin
          beat_capture = 1'b1;
          beat_step    = 1'b1;
          state_next   = last_beat ? l1d_pkg::st_fill_write : l1d_pkg::st_fill_req;
        end
      end
      l1d_pkg::st_fill_write:
      begin
        line_fill  = 1'b1;
        state_next = l1d_pkg::st_idle;
      end
      // Write goes out at once, the line merges only on a hit
      l1d_pkg::st_lookup_write:
      begin
        mem_req    = 1'b1;
        mem_write  = 1'b1;
        store_hit  = 1'b1;
        state_next = l1d_pkg::st_store_wait;
      end
      l1d_pkg::st_store_wait:
      begin
        if (!mem_wait)
          state_next = l1d_pkg::st_idle;
      end
      default:
        state_next = l1d_pkg::st_idle;
    endcase
  end

endmodule

`default_nettype wire

//--- cache/fill_buffer.sv
// Refill line buffer and core read word register
// Collects the four memory beats and picks the word returned to the core
`timescale 1ns/1ps
`default_nettype none

module fill_buffer (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire   [l1d_pkg::data_w-1:0]         mem_rdata,
  input  wire   [l1d_pkg::word_sel_w-1:0]     beat,
  input  wire                                 beat_capture,
  input  wire   [l1d_pkg::word_sel_w-1:0]     req_word,
  input  wire   [l1d_pkg::line_w-1:0]         rd_line,
  input  wire                                 hit_capture,
  output logic  [l1d_pkg::line_w-1:0]         fill_line,
  output logic  [l1d_pkg::data_w-1:0]         core_rdata
);

  // Each beat lands in its own word slot
  always_ff @(posedge clk)
  begin
    if (beat_capture)
      fill_line[beat*l1d_pkg::data_w +: l1d_pkg::data_w] <= mem_rdata;
  end

  // ==============================
  // Core read word
  // ==============================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      core_rdata <= '0;
    else if (hit_capture)
      core_rdata <= rd_line[req_word*l1d_pkg::data_w +: l1d_pkg::data_w];
    else if (beat_capture && (beat == req_word))
      // requested word straight from memory
      core_rdata <= mem_rdata;
  end

endmodule

`default_nettype wire

//--- cache/line_store.sv
// Line store with data, tag and valid arrays
// Synchronous read, tag compare and byte-enabled merge on store hits
`timescale 1ns/1ps
`default_nettype none

module line_store (
  input  wire                              clk,
  input  wire                              rst,
  input  wire   [l1d_pkg::index_w-1:0]     lookup_index,
  input  l1d_pkg::addr_t                   req_addr,
  input  wire   [l1d_pkg::data_w-1:0]      req_wdata,
  input  l1d_pkg::access_size_e            req_size,
  input  wire                              line_fill,
  input  wire   [l1d_pkg::line_w-1:0]      fill_line,
  input  wire                              store_hit,
  output logic                             hit,
  output logic  [l1d_pkg::line_w-1:0]      rd_line
);

  localparam int line_bytes = l1d_pkg::line_w / 8;

  logic [l1d_pkg::line_w-1:0] data_mem [l1d_pkg::line_count];
  logic [l1d_pkg::tag_w-1:0]  tag_mem  [l1d_pkg::line_count];
  logic [l1d_pkg::line_count-1:0] valid_bits;

  logic [l1d_pkg::tag_w-1:0]  rd_tag;
  logic                       rd_valid;
  logic [line_bytes-1:0]      line_be;
  logic [l1d_pkg::line_w-1:0] store_line;

  // Byte enables placed at the selected word
  always_comb
  begin
    line_be = '0;
    line_be[req_addr.word*4 +: 4] = l1d_pkg::lane_mask(req_size, req_addr.byte_sel);
    store_line = {l1d_pkg::words_per_line{l1d_pkg::replicate_wdata(req_size, req_wdata)}};
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_bits <= '0;
      rd_valid   <= 1'b0;
    end
    else
    begin
      if (line_fill)
        valid_bits[req_addr.index] <= 1'b1;
      rd_valid <= valid_bits[lookup_index];
    end
  end

  always_ff @(posedge clk)
  begin
    if (line_fill)
    begin
      data_mem[req_addr.index] <= fill_line;
      tag_mem[req_addr.index]  <= req_addr.tag;
    end
    else if (store_hit && hit)
    begin
      for (int b = 0; b < line_bytes; b++)
      begin
        if (line_be[b])
          data_mem[req_addr.index][b*8 +: 8] <= store_line[b*8 +: 8];
      end
    end
    rd_line <= data_mem[lookup_index];
    rd_tag  <= tag_mem[lookup_index];
  end

  // Compare against the latched request tag
  assign hit = rd_valid && (rd_tag == req_addr.tag);

endmodule

`default_nettype wire

//--- cache/refill_beat_counter.sv
// Refill beat counter
// Steps once per completed beat and flags the last word of the line
`timescale 1ns/1ps
`default_nettype none

module refill_beat_counter (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                beat_clear,
  input  wire                                beat_step,
  output logic [l1d_pkg::word_sel_w-1:0]     beat,
  output logic                               last_beat
);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      beat <= '0;
    else if (beat_clear)
      beat <= '0;
    else if (beat_step)
      beat <= beat + 1'b1;
  end

  assign last_beat = (beat == l1d_pkg::word_sel_w'(l1d_pkg::words_per_line - 1));

endmodule

`default_nettype wire

//--- common/l1d_pkg.sv
// Shared definitions for the L1 data cache
// Address field widths, cache geometry and the address struct
// Access size and controller state enums
// Byte lane and write data replication helpers
`default_nettype none

package l1d_pkg;

  // ==============================
  // Geometry
  // ==============================
  localparam int addr_w         = 32;
  localparam int tag_w          = 22;
  localparam int index_w        = 6;
  localparam int line_count     = 64;
  localparam int words_per_line = 4;
  localparam int word_sel_w     = 2;
  localparam int byte_sel_w     = 2;
  localparam int data_w         = 32;
  localparam int line_w         = data_w * words_per_line;

  // Byte address split, tag on top
  typedef struct packed {
    logic [tag_w-1:0]      tag;
    logic [index_w-1:0]    index;
    logic [word_sel_w-1:0] word;
    logic [byte_sel_w-1:0] byte_sel;
  } addr_t;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_e;

  typedef enum logic [2:0] {
    st_idle         = 3'd0,
    st_lookup_read  = 3'd1,
    st_lookup_write = 3'd2,
    st_fill_req     = 3'd3,
    st_fill_wait    = 3'd4,
    st_fill_write   = 3'd5,
    st_store_wait   = 3'd6
  } ctrl_state_e;

  // ==============================
  // Write rule
  // ==============================
  // Lanes touched inside one word
  function automatic logic [3:0] lane_mask(access_size_e size,
                                           logic [byte_sel_w-1:0] byte_sel);
    logic [3:0] mask;
    case (size)
      size_byte: mask = 4'b0001 << byte_sel;
      size_half: mask = byte_sel[1] ? 4'b1100 : 4'b0011;
      default:   mask = 4'b1111;
    endcase
    return mask;
  endfunction

  // Same data copied into every lane
  function automatic logic [data_w-1:0] replicate_wdata(access_size_e size,
                                                        logic [data_w-1:0] wdata);
    logic [data_w-1:0] rep;
    case (size)
      size_byte: rep = {4{wdata[7:0]}};
      size_half: rep = {2{wdata[15:0]}};
      default:   rep = wdata;
    endcase
    return rep;
  endfunction

endpackage

`default_nettype wire
